// File: logic/bitparse_defs.svh
`ifndef BITPARSE_DEFS_SVH
`define BITPARSE_DEFS_SVH

// source word and funnel window widths
`define BP_WORD_W 128
`define BP_WIN_W 255

// refill allowed while fill after consume is below this
`define BP_REFILL_LEVEL 128

// longest header is 11 bits
`define BP_MIN_FILL 16

`define BP_STEP_W 3

// 2x2 flags per block prediction block
`define BP_NUM_SUB 4

`endif

// File: logic/bitstream_pkg.sv
`include "bitparse_defs.svh"

package bitstream_pkg;

  // one source word from the bitstream
  typedef logic [`BP_WORD_W-1:0] word_t;

  // top of the funnel window, msb is the next bit
  typedef logic [`BP_WORD_W-1:0] window_t;

  // bits held in the window, up to 255
  typedef logic [7:0] fill_t;

  // bits removed per block, 2 to 11
  typedef logic [3:0] bit_count_t;

endpackage

// File: logic/block_hdr_pkg.sv
`include "bitparse_defs.svh"

package block_hdr_pkg;

  typedef enum logic [1:0] {
    mode_xfm = 2'd0,
    mode_bp  = 2'd1,
    mode_mpp = 2'd2
  } mode_e;

  typedef enum logic [1:0] {
    csc_rgb   = 2'd0,
    csc_ycocg = 2'd1,
    csc_ycbcr = 2'd2
  } csc_e;

  typedef logic [2:0] flat_t;
  typedef logic [`BP_STEP_W-1:0] step_t;
  typedef logic [`BP_NUM_SUB-1:0] use2x2_t;

  // flatness type when the flatness flag is clear
  localparam flat_t flat_none = 3'd4;

endpackage

// File: logic/parse_ifs.sv
// window from funnel shifter to header decoder
interface window_if;
  bitstream_pkg::window_t win;
  logic win_valid;
  logic take;
  bitstream_pkg::bit_count_t take_bits;

  modport source (output win, output win_valid, input take, input take_bits);
  modport sink (input win, input win_valid, output take, output take_bits);
endinterface

// decoded block header, valid/ready
interface blk_if;
  logic valid;
  logic ready;
  logic same_flag;
  block_hdr_pkg::mode_e mode;
  block_hdr_pkg::flat_t flat;
  block_hdr_pkg::csc_e csc;
  block_hdr_pkg::step_t step;
  block_hdr_pkg::use2x2_t use2x2;
  bitstream_pkg::bit_count_t bits;

  modport source (
    output valid, output same_flag, output mode, output flat,
    output csc, output step, output use2x2, output bits,
    input ready
  );
  modport sink (
    input valid, input same_flag, input mode, input flat,
    input csc, input step, input use2x2, input bits,
    output ready
  );
endinterface

// File: logic/funnel_shifter.sv
`include "bitparse_defs.svh"

module funnel_shifter (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 word_valid,
  input  bitstream_pkg::word_t word_data,
  output logic                 word_rd,
  window_if.source             win
);

  logic [`BP_WIN_W-1:0] window_q;
  logic [`BP_WIN_W-1:0] window_shifted;
  logic [`BP_WIN_W-1:0] word_placed;
  bitstream_pkg::fill_t fill_q;
  bitstream_pkg::fill_t fill_left;
  bitstream_pkg::bit_count_t consume;

  assign consume = win.take ? win.take_bits : '0;

  // fill once this cycle's header is removed
  assign fill_left = fill_q - bitstream_pkg::fill_t'(consume);

  assign window_shifted = window_q << consume;

  // new word lands right after the remaining bits
  assign word_placed = {word_data, {(`BP_WIN_W-`BP_WORD_W){1'b0}}} >> fill_left;

  assign word_rd = word_valid && (fill_left < `BP_REFILL_LEVEL);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      fill_q <= '0;
    end
    else if (word_rd)
    begin
      fill_q <= fill_left + bitstream_pkg::fill_t'(`BP_WORD_W);
    end
    else
    begin
      fill_q <= fill_left;
    end
  end

  // bits below the fill level stay zero so the word can be or-ed in
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      window_q <= '0;
    end
    else if (word_rd)
    begin
      window_q <= window_shifted | word_placed;
    end
    else
    begin
      window_q <= window_shifted;
    end
  end

  assign win.win = window_q[`BP_WIN_W-1 -: `BP_WORD_W];
  assign win.win_valid = (fill_q >= `BP_MIN_FILL);

endmodule

// File: logic/header_decoder.sv
`include "bitparse_defs.svh"

module header_decoder (
  input logic    clk,
  input logic    rstn,
  window_if.sink win,
  blk_if.source  blk
);

  block_hdr_pkg::mode_e prev_mode;
  block_hdr_pkg::mode_e mode;
  logic same;
  logic [1:0] code;
  logic flat_flag;
  logic xfer;
  bitstream_pkg::bit_count_t mode_bits;
  bitstream_pkg::bit_count_t flat_bits;
  bitstream_pkg::bit_count_t body_bits;
  bitstream_pkg::window_t after_mode;
  bitstream_pkg::window_t after_flat;

  assign same = win.win[127];
  assign code = win.win[126:125];

  // mode header, escape code 3 picks transform or block prediction
  always_comb
  begin
    if (same)
    begin
      mode = prev_mode;
      mode_bits = 4'd1;
    end
    else if (code == 2'd3)
    begin
      mode = win.win[124] ? block_hdr_pkg::mode_bp : block_hdr_pkg::mode_xfm;
      mode_bits = 4'd4;
    end
    else
    begin
      mode = block_hdr_pkg::mode_e'(code);
      mode_bits = 4'd3;
    end
  end

  assign after_mode = win.win << mode_bits;
  assign flat_flag = after_mode[127];
  assign flat_bits = flat_flag ? 4'd3 : 4'd1;
  assign after_flat = after_mode << flat_bits;

  always_comb
  begin
    blk.csc = block_hdr_pkg::csc_rgb;
    blk.step = '0;
    blk.use2x2 = '0;
    body_bits = '0;
    case (mode)
      block_hdr_pkg::mode_mpp:
      begin
        // source is rgb, so the csc bit is always sent
        blk.csc = after_flat[127] ? block_hdr_pkg::csc_ycocg : block_hdr_pkg::csc_rgb;
        blk.step = after_flat[126 -: `BP_STEP_W];
        body_bits = 4'd1 + 4'(`BP_STEP_W);
      end
      block_hdr_pkg::mode_bp:
      begin
        // first bit is flag 0
        for (int i = 0; i < `BP_NUM_SUB; i++)
        begin
          blk.use2x2[i] = after_flat[127-i];
        end
        body_bits = 4'(`BP_NUM_SUB);
      end
      default:
      begin
        body_bits = '0;
      end
    endcase
  end

  assign blk.valid = win.win_valid;
  assign blk.same_flag = same;
  assign blk.mode = mode;
  assign blk.flat = flat_flag ? {1'b0, after_mode[126:125]} : block_hdr_pkg::flat_none;
  assign blk.bits = mode_bits + flat_bits + body_bits;

  assign xfer = blk.valid && blk.ready;
  assign win.take = xfer;
  assign win.take_bits = blk.bits;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      prev_mode <= block_hdr_pkg::mode_xfm;
    end
    else if (xfer)
    begin
      prev_mode <= mode;
    end
  end

endmodule

// File: logic/block_out_stage.sv
module block_out_stage (
  input  logic                       clk,
  input  logic                       rstn,
  blk_if.sink                        blk,
  output logic                       blk_valid,
  input  logic                       blk_ready,
  output logic                       blk_same,
  output block_hdr_pkg::mode_e       blk_mode,
  output block_hdr_pkg::flat_t       blk_flat,
  output block_hdr_pkg::csc_e        blk_csc,
  output block_hdr_pkg::step_t       blk_step,
  output block_hdr_pkg::use2x2_t     blk_use2x2,
  output bitstream_pkg::bit_count_t  blk_bits
);

  logic full;

  // accept when empty or when the held result leaves this cycle
  assign blk.ready = !full || blk_ready;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      full <= 1'b0;
    end
    else if (blk.ready)
    begin
      full <= blk.valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (blk.valid && blk.ready)
    begin
      blk_same <= blk.same_flag;
      blk_mode <= blk.mode;
      blk_flat <= blk.flat;
      blk_csc <= blk.csc;
      blk_step <= blk.step;
      blk_use2x2 <= blk.use2x2;
      blk_bits <= blk.bits;
    end
  end

  assign blk_valid = full;

endmodule

// File: logic/bitparse_top.sv
module bitparse_top (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       word_valid,
  input  bitstream_pkg::word_t       word_data,
  output logic                       word_rd,
  output logic                       blk_valid,
  input  logic                       blk_ready,
  output logic                       blk_same,
  output block_hdr_pkg::mode_e       blk_mode,
  output block_hdr_pkg::flat_t       blk_flat,
  output block_hdr_pkg::csc_e        blk_csc,
  output block_hdr_pkg::step_t       blk_step,
  output block_hdr_pkg::use2x2_t     blk_use2x2,
  output bitstream_pkg::bit_count_t  blk_bits
);

  window_if u_win ();
  blk_if u_blk ();

  funnel_shifter u_funnel_shifter (
    .clk        (clk),
    .rstn       (rstn),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_rd    (word_rd),
    .win        (u_win.source)
  );

  header_decoder u_header_decoder (
    .clk  (clk),
    .rstn (rstn),
    .win  (u_win.sink),
    .blk  (u_blk.source)
  );

  block_out_stage u_block_out_stage (
    .clk        (clk),
    .rstn       (rstn),
    .blk        (u_blk.sink),
    .blk_valid  (blk_valid),
    .blk_ready  (blk_ready),
    .blk_same   (blk_same),
    .blk_mode   (blk_mode),
    .blk_flat   (blk_flat),
    .blk_csc    (blk_csc),
    .blk_step   (blk_step),
    .blk_use2x2 (blk_use2x2),
    .blk_bits   (blk_bits)
  );

endmodule

// File: tests/bitparse_props.sv
module bitparse_props (
  input logic                      clk,
  input logic                      rstn,
  input logic                      word_valid,
  input logic                      word_rd,
  input logic                      blk_valid,
  input logic                      blk_ready,
  input logic                      blk_same,
  input block_hdr_pkg::mode_e      blk_mode,
  input block_hdr_pkg::flat_t      blk_flat,
  input block_hdr_pkg::csc_e       blk_csc,
  input block_hdr_pkg::step_t      blk_step,
  input block_hdr_pkg::use2x2_t    blk_use2x2,
  input bitstream_pkg::bit_count_t blk_bits
);

  int unsigned fails = 0;

  // a word is only taken when one is offered
  a_rd_needs_valid: assert property (@(posedge clk) disable iff (!rstn)
    word_rd |-> word_valid)
  else
  begin
    $error("word_rd high without word_valid");
    fails++;
  end

  // held result stays put under back-pressure
  a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
    (blk_valid && !blk_ready) |=> (blk_valid &&
      $stable({blk_same, blk_mode, blk_flat, blk_csc, blk_step, blk_use2x2, blk_bits})))
  else
  begin
    $error("block result changed while stalled");
    fails++;
  end

  a_bits_range: assert property (@(posedge clk) disable iff (!rstn)
    blk_valid |-> (blk_bits >= 4'd2 && blk_bits <= 4'd11))
  else
  begin
    $error("blk_bits out of range");
    fails++;
  end

endmodule

bind bitparse_top bitparse_props u_props (.*);

// File: tests/bitparse_tb.sv
module bitparse_tb;

  localparam int NBLK = 120;
  localparam int STREAM_BITS = 2048;
  localparam int CYCLE_LIMIT = 3000;

  // msb of each 128-bit slice is the first bit of the stream
  typedef logic [0:STREAM_BITS-1] stream_t;

  typedef struct packed {
    logic                      same;
    block_hdr_pkg::mode_e      mode;
    block_hdr_pkg::flat_t      flat;
    block_hdr_pkg::csc_e       csc;
    block_hdr_pkg::step_t      step;
    block_hdr_pkg::use2x2_t    use2x2;
    bitstream_pkg::bit_count_t bits;
  } hdr_t;

  logic clk;
  logic rstn;
  logic word_valid;
  bitstream_pkg::word_t word_data;
  logic word_rd;
  logic blk_valid;
  logic blk_ready;
  logic blk_same;
  block_hdr_pkg::mode_e blk_mode;
  block_hdr_pkg::flat_t blk_flat;
  block_hdr_pkg::csc_e blk_csc;
  block_hdr_pkg::step_t blk_step;
  block_hdr_pkg::use2x2_t blk_use2x2;
  bitstream_pkg::bit_count_t blk_bits;

  int unsigned lcg_state;
  stream_t stream;
  int stream_len;
  int word_idx;
  int exp_pos;
  block_hdr_pkg::mode_e exp_prev;
  int got;
  logic checking;
  string test_name;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  int blocks_checked;

  bitparse_top DUT (
    .clk        (clk),
    .rstn       (rstn),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_rd    (word_rd),
    .blk_valid  (blk_valid),
    .blk_ready  (blk_ready),
    .blk_same   (blk_same),
    .blk_mode   (blk_mode),
    .blk_flat   (blk_flat),
    .blk_csc    (blk_csc),
    .blk_step   (blk_step),
    .blk_use2x2 (blk_use2x2),
    .blk_bits   (blk_bits)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic put_bits(input int unsigned value, input int n);
    for (int i = n - 1; i >= 0; i--)
    begin
      stream[stream_len] = value[i];
      stream_len++;
    end
  endtask

  // random headers with the same flag set at same_pct percent
  // first_same makes the first header repeat the reset mode
  task automatic build_stream(input int same_pct, input bit first_same);
    logic [1:0] mode;
    int unsigned code;
    int unsigned flag;
    stream = '0;
    stream_len = 0;
    mode = 2'd0;
    for (int b = 0; b < NBLK; b++)
    begin
      if ((b == 0 && first_same) || (next_rand() % 100) < same_pct)
      begin
        put_bits(1, 1);
      end
      else
      begin
        put_bits(0, 1);
        code = next_rand() % 4;
        put_bits(code, 2);
        if (code == 3)
        begin
          code = next_rand() % 2;
          put_bits(code, 1);
        end
        mode = code[1:0];
      end
      flag = next_rand() % 2;
      put_bits(flag, 1);
      if (flag != 0)
      begin
        put_bits(next_rand() % 4, 2);
      end
      // csc and step for midpoint or four flags for block prediction
      if (mode != 2'd0)
      begin
        put_bits(next_rand() % 16, 4);
      end
    end
  endtask

  function automatic hdr_t decode_ref(input stream_t s, input int pos,
                                      input block_hdr_pkg::mode_e prev);
    hdr_t h;
    int p;
    h = '0;
    p = pos;
    h.same = s[p];
    p++;
    if (h.same)
    begin
      h.mode = prev;
    end
    else if (s[p] && s[p+1])
    begin
      h.mode = s[p+2] ? block_hdr_pkg::mode_bp : block_hdr_pkg::mode_xfm;
      p += 3;
    end
    else
    begin
      h.mode = block_hdr_pkg::mode_e'({s[p], s[p+1]});
      p += 2;
    end
    if (s[p])
    begin
      h.flat = {1'b0, s[p+1], s[p+2]};
      p += 3;
    end
    else
    begin
      h.flat = 3'd4;
      p += 1;
    end
    if (h.mode == block_hdr_pkg::mode_mpp)
    begin
      h.csc = s[p] ? block_hdr_pkg::csc_ycocg : block_hdr_pkg::csc_rgb;
      h.step = {s[p+1], s[p+2], s[p+3]};
      p += 4;
    end
    else if (h.mode == block_hdr_pkg::mode_bp)
    begin
      for (int i = 0; i < 4; i++)
      begin
        h.use2x2[i] = s[p+i];
      end
      p += 4;
    end
    h.bits = 4'(p - pos);
    return h;
  endfunction

  function automatic string show_hdr(input hdr_t h);
    return $sformatf("same=%0d mode=%0d flat=%0d csc=%0d step=%0d use2x2=%h bits=%0d",
                     h.same, h.mode, h.flat, h.csc, h.step, h.use2x2, h.bits);
  endfunction

  // word count and result compare on the rising edge
  always @(posedge clk)
  begin
    hdr_t exp_hdr;
    hdr_t act_hdr;
    if (rstn && word_rd)
    begin
      word_idx++;
    end
    if (word_rd && !word_valid)
    begin
      $display("word_rd was high while word_valid was low in test %s", test_name);
      errors++;
      test_errors++;
    end
    if (checking && blk_valid && blk_ready)
    begin
      exp_hdr = decode_ref(stream, exp_pos, exp_prev);
      act_hdr = {blk_same, blk_mode, blk_flat, blk_csc, blk_step, blk_use2x2, blk_bits};
      if (act_hdr !== exp_hdr)
      begin
        $display("[ERROR] %s block %0d expected %s actual %s", test_name, got,
                 show_hdr(exp_hdr), show_hdr(act_hdr));
        errors++;
        test_errors++;
      end
      exp_pos += exp_hdr.bits;
      exp_prev = exp_hdr.mode;
      got++;
      blocks_checked++;
      if (got == NBLK)
      begin
        checking = 1'b0;
      end
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    rstn = 1'b0;
    word_valid = 1'b0;
    word_data = '0;
    blk_ready = 1'b0;
    word_idx = 0;
    repeat (16)
    begin
      @(negedge clk);
      if (word_rd || blk_valid)
      begin
        $display("word_rd or blk_valid went high during reset in test %s", test_name);
        errors++;
        test_errors++;
      end
    end
    rstn = 1'b1;
  endtask

  task automatic drive_cycle(input int gap_pct, input int stall_pct);
    @(negedge clk);
    word_valid = (next_rand() % 100) >= gap_pct;
    word_data = (word_idx < STREAM_BITS / 128) ? stream[word_idx * 128 +: 128] : '0;
    blk_ready = (next_rand() % 100) >= stall_pct;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0)
    begin
      tests_failed++;
    end
    $display("test %s: %0d blocks checked, %0d errors, %s", test_name, got, test_errors,
             (test_errors != 0) ? "failed" : "ok");
  endtask

  task automatic run_stream(input string name, input int same_pct, input int gap_pct,
                            input int stall_pct, input bit reseed, input bit first_same);
    int cycles;
    test_name = name;
    test_errors = 0;
    if (reseed)
    begin
      lcg_state = 51;
    end
    build_stream(same_pct, first_same);
    apply_reset();
    exp_pos = 0;
    exp_prev = block_hdr_pkg::mode_xfm;
    got = 0;
    cycles = 0;
    checking = 1'b1;
    while (got < NBLK && cycles < CYCLE_LIMIT)
    begin
      drive_cycle(gap_pct, stall_pct);
      cycles++;
    end
    checking = 1'b0;
    word_valid = 1'b0;
    if (got < NBLK)
    begin
      $display("timed out in test %s: only %0d of %0d blocks came out", name, got, NBLK);
      errors++;
      test_errors++;
    end
    finish_test();
  endtask

  initial
  begin
    rstn = 1'b0;
    word_valid = 1'b0;
    word_data = '0;
    blk_ready = 1'b0;
    lcg_state = 51;
    checking = 1'b0;
    word_idx = 0;
    got = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    blocks_checked = 0;

    test_name = "reset";
    test_errors = 0;
    apply_reset();
    @(negedge clk);
    if (word_rd || blk_valid)
    begin
      $display("word_rd or blk_valid went high in the first cycle after reset");
      errors++;
      test_errors++;
    end
    finish_test();

    run_stream("random_headers", 25, 0, 0, 1'b1, 1'b0);
    run_stream("same_flag_runs", 75, 0, 0, 1'b0, 1'b1);
    run_stream("ready_stalls", 25, 0, 40, 1'b1, 1'b0);
    run_stream("word_gaps", 25, 35, 0, 1'b1, 1'b0);

    $display("tests %0d, failed %0d, blocks checked %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, blocks_checked, errors, DUT.u_props.fails);
    if (errors == 0 && DUT.u_props.fails == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+logic
logic/bitstream_pkg.sv
logic/block_hdr_pkg.sv
logic/parse_ifs.sv
logic/funnel_shifter.sv
logic/header_decoder.sv
logic/block_out_stage.sv
logic/bitparse_top.sv
tests/bitparse_props.sv
tests/bitparse_tb.sv

// File: Bender.yml
package:
  name: bitparse

sources:
  - include_dirs:
      - logic
    files:
      - logic/bitstream_pkg.sv
      - logic/block_hdr_pkg.sv
      - logic/parse_ifs.sv
      - logic/funnel_shifter.sv
      - logic/header_decoder.sv
      - logic/block_out_stage.sv
      - logic/bitparse_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/bitparse_props.sv
      - tests/bitparse_tb.sv
